//--- hw/cdr_pkg.sv
package cdr_pkg;

    // ------------------------------------------------------------
    // sample, interpolator and accumulator sizes
    // ------------------------------------------------------------
    localparam int NADC    = 8;         // adc sample width
    localparam int NTI     = 4;         // samples per group
    localparam int NPI     = 8;         // interpolator code width
    localparam int NOUT    = 2;         // interpolator outputs
    localparam int PERR_W  = NADC + 4;  // room for NTI pair terms of 2*2^(NADC-1)
    localparam int FREQ_W  = 20;
    localparam int PHASE_W = 24;

    localparam int CFG_AW  = 3;
    localparam int CFG_DW  = 32;

    // ------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------
    typedef logic signed [NADC-1:0]    adc_sample_t;
    typedef logic signed [PERR_W-1:0]  phase_err_t;
    typedef logic signed [FREQ_W-1:0]  freq_est_t;
    typedef logic        [PHASE_W-1:0] phase_acc_t;
    typedef logic        [NPI-1:0]     pi_code_t;
    typedef logic        [2:0]         gain_shift_t;   // left shift applied to the error
    typedef logic        [CFG_AW-1:0]  cfg_addr_t;
    typedef logic        [CFG_DW-1:0]  cfg_data_t;

    // anything not listed in the register map reads back as zero
    localparam cfg_addr_t ADDR_CTRL       = 3'd0;  // bit 0 freq est, bit 1 ext pi, bit 2 sample req
    localparam cfg_addr_t ADDR_GAIN       = 3'd1;  // kp in 2:0, ki in 6:4
    localparam cfg_addr_t ADDR_PD_OFFSET  = 3'd2;
    localparam cfg_addr_t ADDR_EXT_PI     = 3'd3;
    localparam cfg_addr_t ADDR_SNAP_PHASE = 3'd4;
    localparam cfg_addr_t ADDR_SNAP_FREQ  = 3'd5;

    // the snapshot machine makes one capture per rising edge of sample_req
    typedef enum logic [1:0] {
        SNAP_SAMPLE,
        SNAP_WAIT,
        SNAP_READY
    } snap_state_t;

endpackage

//--- hw/mm_pd.sv
`timescale 1ns/1ps

module mm_pd import cdr_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  adc_sample_t din_i [NTI],
    input  phase_err_t  pd_offset_i,
    output phase_err_t  pd_err_o
);

    adc_sample_t last_q;         // newest sample of the previous group
    adc_sample_t seq [NTI+1];    // last_q followed by the current group in oldest first order
    phase_err_t  err_d;
    phase_err_t  pd_err_q;

    always_comb begin
        seq[0] = last_q;
        for (int i = 0; i < NTI; i++) begin
            seq[i+1] = din_i[i];
        end
    end

    // ------------------------------------------------------------
    // mueller-muller error sums sgn(p)*c - sgn(c)*p over adjacent pairs
    // ------------------------------------------------------------
    always_comb begin
        phase_err_t sum;
        phase_err_t p_ext;
        phase_err_t c_ext;
        phase_err_t term_a;
        phase_err_t term_b;
        sum = '0;
        for (int k = 0; k < NTI; k++) begin
            p_ext  = phase_err_t'(seq[k]);               // sign extends to PERR_W
            c_ext  = phase_err_t'(seq[k+1]);
            term_a = seq[k][NADC-1]   ? -c_ext : c_ext;  // zero counts as positive
            term_b = seq[k+1][NADC-1] ? -p_ext : p_ext;
            sum    = sum + term_a - term_b;
        end
        err_d = sum - pd_offset_i;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q   <= '0;
            pd_err_q <= '0;
        end else begin
            last_q   <= din_i[NTI-1];
            pd_err_q <= err_d;
        end
    end

    assign pd_err_o = pd_err_q;

endmodule

//--- hw/cdr_loop_filter.sv
`timescale 1ns/1ps

module cdr_loop_filter import cdr_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  phase_err_t  pd_err_i,
    input  gain_shift_t kp_i,
    input  gain_shift_t ki_i,
    input  logic        en_freq_est_i,
    input  logic        en_ext_pi_i,
    input  pi_code_t    ext_pi_i,
    input  logic        sample_req_i,
    output pi_code_t    pi_ctl_o [NOUT],
    output logic        freq_lvl_cross_o,
    output phase_acc_t  snap_phase_o,
    output freq_est_t   snap_freq_o
);

    phase_acc_t  phase_q;
    phase_acc_t  phase_next;
    freq_est_t   freq_q;
    freq_est_t   freq_next;
    freq_est_t   prev_freq_next_q;   // last cycle's update feeds the crossing flag
    freq_est_t   err_f;
    logic signed [PHASE_W-1:0] err_p;
    logic signed [PHASE_W-1:0] freq_p;
    pi_code_t    pi_int;
    snap_state_t snap_state;

    // ------------------------------------------------------------
    // second order loop
    // ------------------------------------------------------------
    assign err_f  = freq_est_t'(pd_err_i);   // sign extend into the integrator width
    assign err_p  = PHASE_W'(pd_err_i);
    assign freq_p = PHASE_W'(freq_q);

    always_comb begin
        freq_next  = en_freq_est_i ? (freq_q + (err_f << ki_i)) : '0;
        // proportional path and old frequency both wrap at PHASE_W
        phase_next = phase_q + phase_acc_t'(err_p << kp_i) + phase_acc_t'(freq_p);
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_q          <= '0;
            freq_q           <= '0;
            prev_freq_next_q <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            phase_q          <= phase_next;
            freq_q           <= freq_next;
            prev_freq_next_q <= freq_next;
            freq_lvl_cross_o <= (freq_next > prev_freq_next_q);
        end
    end

    // interpolator code is the top of the phase accumulator
    assign pi_int = phase_q[PHASE_W-1 -: NPI];

    always_comb begin
        for (int k = 0; k < NOUT; k++) begin
            pi_ctl_o[k] = en_ext_pi_i ? ext_pi_i : pi_int;
        end
    end

    // ------------------------------------------------------------
    // snapshot of the loop state
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            snap_state   <= SNAP_WAIT;
            snap_phase_o <= '0;
            snap_freq_o  <= '0;
        end else begin
            case (snap_state)
                SNAP_SAMPLE: begin
                    snap_phase_o <= phase_q;
                    snap_freq_o  <= freq_next;
                    snap_state   <= SNAP_WAIT;
                end
                SNAP_WAIT: begin
                    // arm only once the request bit has gone low again
                    if (!sample_req_i) begin
                        snap_state <= SNAP_READY;
                    end
                end
                SNAP_READY: begin
                    if (sample_req_i) begin
                        snap_state <= SNAP_SAMPLE;
                    end
                end
                default: snap_state <= SNAP_WAIT;
            endcase
        end
    end

endmodule

//--- hw/cdr_cfg_regs.sv
`timescale 1ns/1ps

module cdr_cfg_regs import cdr_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  logic        cfg_we_i,
    input  cfg_addr_t   cfg_addr_i,
    input  cfg_data_t   cfg_wdata_i,
    input  phase_acc_t  snap_phase_i,
    input  freq_est_t   snap_freq_i,
    output cfg_data_t   cfg_rdata_o,
    output gain_shift_t kp_o,
    output gain_shift_t ki_o,
    output logic        en_freq_est_o,
    output logic        en_ext_pi_o,
    output pi_code_t    ext_pi_o,
    output logic        sample_req_o,
    output phase_err_t  pd_offset_o
);

    gain_shift_t kp_q;
    gain_shift_t ki_q;
    logic        en_freq_est_q;
    logic        en_ext_pi_q;
    logic        sample_req_q;
    pi_code_t    ext_pi_q;
    phase_err_t  pd_offset_q;

    cfg_data_t   pd_offset_ext;
    cfg_data_t   snap_phase_ext;
    cfg_data_t   snap_freq_ext;

    // ------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            kp_q          <= '0;
            ki_q          <= '0;
            en_freq_est_q <= 1'b0;
            en_ext_pi_q   <= 1'b0;
            sample_req_q  <= 1'b0;
            ext_pi_q      <= '0;
            pd_offset_q   <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                ADDR_CTRL: begin
                    en_freq_est_q <= cfg_wdata_i[0];
                    en_ext_pi_q   <= cfg_wdata_i[1];
                    sample_req_q  <= cfg_wdata_i[2];
                end
                ADDR_GAIN: begin
                    kp_q <= cfg_wdata_i[2:0];
                    ki_q <= cfg_wdata_i[6:4];
                end
                ADDR_PD_OFFSET: pd_offset_q <= cfg_wdata_i[PERR_W-1:0];
                ADDR_EXT_PI:    ext_pi_q    <= cfg_wdata_i[NPI-1:0];
                default: ;      // snapshots are read only
            endcase
        end
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    assign pd_offset_ext  = {{(CFG_DW-PERR_W){pd_offset_q[PERR_W-1]}}, pd_offset_q};
    assign snap_phase_ext = {{(CFG_DW-PHASE_W){1'b0}}, snap_phase_i};
    assign snap_freq_ext  = {{(CFG_DW-FREQ_W){snap_freq_i[FREQ_W-1]}}, snap_freq_i};

    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            ADDR_CTRL: begin
                cfg_rdata_o[0] = en_freq_est_q;
                cfg_rdata_o[1] = en_ext_pi_q;
                cfg_rdata_o[2] = sample_req_q;
            end
            ADDR_GAIN: begin
                cfg_rdata_o[2:0] = kp_q;
                cfg_rdata_o[6:4] = ki_q;
            end
            ADDR_PD_OFFSET:  cfg_rdata_o = pd_offset_ext;
            ADDR_EXT_PI:     cfg_rdata_o[NPI-1:0] = ext_pi_q;
            ADDR_SNAP_PHASE: cfg_rdata_o = snap_phase_ext;
            ADDR_SNAP_FREQ:  cfg_rdata_o = snap_freq_ext;
            default:         cfg_rdata_o = '0;
        endcase
    end

    assign kp_o          = kp_q;
    assign ki_o          = ki_q;
    assign en_freq_est_o = en_freq_est_q;
    assign en_ext_pi_o   = en_ext_pi_q;
    assign sample_req_o  = sample_req_q;
    assign ext_pi_o      = ext_pi_q;
    assign pd_offset_o   = pd_offset_q;

endmodule

//--- hw/mm_cdr_top.sv
`timescale 1ns/1ps

module mm_cdr_top import cdr_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  adc_sample_t din_i [NTI],   // one group per cycle, sample 0 oldest
    input  logic        cfg_we_i,
    input  cfg_addr_t   cfg_addr_i,
    input  cfg_data_t   cfg_wdata_i,
    output cfg_data_t   cfg_rdata_o,
    output pi_code_t    pi_ctl_o [NOUT],
    output logic        freq_lvl_cross_o
);

    phase_err_t  pd_err;
    phase_err_t  pd_offset;
    gain_shift_t kp;
    gain_shift_t ki;
    logic        en_freq_est;
    logic        en_ext_pi;
    logic        sample_req;
    pi_code_t    ext_pi;
    phase_acc_t  snap_phase;
    freq_est_t   snap_freq;

    mm_pd u_pd (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (pd_offset),
        .pd_err_o    (pd_err)
    );

    cdr_loop_filter u_loop (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .kp_i             (kp),
        .ki_i             (ki),
        .en_freq_est_i    (en_freq_est),
        .en_ext_pi_i      (en_ext_pi),
        .ext_pi_i         (ext_pi),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .snap_phase_o     (snap_phase),
        .snap_freq_o      (snap_freq)
    );

    cdr_cfg_regs u_regs (
        .clk           (clk),
        .ext_rstb      (ext_rstb),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .snap_phase_i  (snap_phase),
        .snap_freq_i   (snap_freq),
        .cfg_rdata_o   (cfg_rdata_o),
        .kp_o          (kp),
        .ki_o          (ki),
        .en_freq_est_o (en_freq_est),
        .en_ext_pi_o   (en_ext_pi),
        .ext_pi_o      (ext_pi),
        .sample_req_o  (sample_req),
        .pd_offset_o   (pd_offset)
    );

endmodule

//--- verif/mm_cdr_properties.sv
`timescale 1ns/1ps

module mm_cdr_properties import cdr_pkg::*; (
    input logic     clk,
    input logic     ext_rstb,
    input pi_code_t pi_ctl_i [NOUT],
    input logic     freq_lvl_cross_i,
    input logic     en_ext_pi_i,
    input pi_code_t ext_pi_i
);

    // ------------------------------------------------------------
    // interpolator outputs
    // ------------------------------------------------------------
    for (genvar k = 1; k < NOUT; k++) begin : g_same
        a_outputs_equal: assert property (@(posedge clk) disable iff (!ext_rstb)
            pi_ctl_i[k] == pi_ctl_i[0])
            else $error("interpolator output %0d differs from output 0", k);
    end

    a_override: assert property (@(posedge clk) disable iff (!ext_rstb)
        en_ext_pi_i |-> pi_ctl_i[0] == ext_pi_i)
        else $error("override enabled but the code is not ext_pi");

    // the first edge after release still sees the reset values
    a_reset_zero: assert property (@(posedge clk)
        $rose(ext_rstb) |-> (pi_ctl_i[0] == '0) && !freq_lvl_cross_i)
        else $error("outputs not zero right after reset");

endmodule

bind mm_cdr_top mm_cdr_properties u_props (
    .clk              (clk),
    .ext_rstb         (ext_rstb),
    .pi_ctl_i         (pi_ctl_o),
    .freq_lvl_cross_i (freq_lvl_cross_o),
    .en_ext_pi_i      (en_ext_pi),
    .ext_pi_i         (ext_pi)
);

//--- verif/tb_mm_cdr.sv
`timescale 1ns/1ps

module tb_mm_cdr import cdr_pkg::*; ();

    logic        clk = 1'b0;
    logic        ext_rstb;
    adc_sample_t din [NTI];
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    cfg_data_t   cfg_wdata;
    cfg_data_t   cfg_rdata;
    pi_code_t    pi_ctl [NOUT];
    logic        freq_cross;

    logic [31:0] lfsr = 32'hbc1b196d;
    logic        drive_on = 1'b0;
    int          pi_errs = 0;
    int          cross_errs = 0;
    int          reg_errs = 0;

    // reference loop state and the register values written so far
    adc_sample_t m_last;
    phase_err_t  m_pd;
    phase_acc_t  m_phase;
    freq_est_t   m_freq;
    freq_est_t   m_prev_fn;
    logic        m_cross;
    phase_acc_t  m_snap_phase;
    freq_est_t   m_snap_freq;
    int          m_snap_st;          // 0 wait, 1 ready, 2 sample
    gain_shift_t s_kp;
    gain_shift_t s_ki;
    logic        s_enf;
    logic        s_enx;
    logic        s_sreq;
    pi_code_t    s_ext;
    phase_err_t  s_off;

    mm_cdr_top u_dut (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .cfg_we_i         (cfg_we),
        .cfg_addr_i       (cfg_addr),
        .cfg_wdata_i      (cfg_wdata),
        .cfg_rdata_o      (cfg_rdata),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_cross)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic int sgn(int v);
        return (v >= 0) ? 1 : -1;
    endfunction

    function automatic phase_err_t mm_error(adc_sample_t prev, adc_sample_t grp [NTI],
                                            phase_err_t off);
        int p;
        int c;
        int acc;
        acc = 0;
        p   = int'(prev);
        for (int i = 0; i < NTI; i++) begin
            c   = int'(grp[i]);
            acc = acc + sgn(p) * c - sgn(c) * p;
            p   = c;
        end
        return phase_err_t'(acc - int'(off));
    endfunction

    function automatic freq_est_t freq_update(freq_est_t f, phase_err_t e, gain_shift_t ki,
                                              logic en);
        if (!en) begin
            return '0;
        end
        return freq_est_t'(int'(f) + (int'(e) <<< ki));
    endfunction

    function automatic phase_acc_t phase_update(phase_acc_t ph, phase_err_t e, gain_shift_t kp,
                                                freq_est_t f);
        return phase_acc_t'(int'(ph) + (int'(e) <<< kp) + int'(f));
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    always @(posedge clk or negedge ext_rstb) begin
        freq_est_t  fn;
        phase_acc_t pn;
        phase_err_t pd_new;
        if (!ext_rstb) begin
            m_last       = '0;
            m_pd         = '0;
            m_phase      = '0;
            m_freq       = '0;
            m_prev_fn    = '0;
            m_cross      = 1'b0;
            m_snap_phase = '0;
            m_snap_freq  = '0;
            m_snap_st    = 0;
            s_kp         = '0;
            s_ki         = '0;
            s_enf        = 1'b0;
            s_enx        = 1'b0;
            s_sreq       = 1'b0;
            s_ext        = '0;
            s_off        = '0;
        end else begin
            fn     = freq_update(m_freq, m_pd, s_ki, s_enf);
            pn     = phase_update(m_phase, m_pd, s_kp, m_freq);
            pd_new = mm_error(m_last, din, s_off);
            case (m_snap_st)
                2: begin
                    m_snap_phase = m_phase;
                    m_snap_freq  = fn;
                    m_snap_st    = 0;
                end
                1: if (s_sreq) m_snap_st = 2;
                default: if (!s_sreq) m_snap_st = 1;
            endcase
            m_cross   = (fn > m_prev_fn);
            m_prev_fn = fn;
            m_freq    = fn;
            m_phase   = pn;
            m_pd      = pd_new;
            m_last    = din[NTI-1];
            if (cfg_we) begin   // new register values apply from the next edge on
                case (cfg_addr)
                    ADDR_CTRL: begin
                        s_enf  = cfg_wdata[0];
                        s_enx  = cfg_wdata[1];
                        s_sreq = cfg_wdata[2];
                    end
                    ADDR_GAIN: begin
                        s_kp = cfg_wdata[2:0];
                        s_ki = cfg_wdata[6:4];
                    end
                    ADDR_PD_OFFSET: s_off = cfg_wdata[PERR_W-1:0];
                    ADDR_EXT_PI:    s_ext = cfg_wdata[NPI-1:0];
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus and comparison
    // ------------------------------------------------------------
    task automatic draw_sample(output adc_sample_t v);
        for (int b = 0; b < NADC; b++) begin
            v[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    always @(posedge clk) begin
        if (drive_on) begin
            #1;
            for (int i = 0; i < NTI; i++) begin
                draw_sample(din[i]);
            end
        end
    end

    always @(negedge clk) begin
        pi_code_t exp_code;
        if (ext_rstb) begin
            exp_code = s_enx ? s_ext : m_phase[PHASE_W-1 -: NPI];
            for (int k = 0; k < NOUT; k++) begin
                assert (pi_ctl[k] == exp_code) else begin
                    pi_errs++;
                    $display("CHECK FAILED pi_ctl_o[%0d] got %h expected %h", k, pi_ctl[k],
                             exp_code);
                end
            end
            assert (freq_cross == m_cross) else begin
                cross_errs++;
                $display("CHECK FAILED freq_lvl_cross_o got %h expected %h", freq_cross, m_cross);
            end
        end
    end

    task automatic wait_cycles(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic write_reg(cfg_addr_t addr, cfg_data_t data);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we    = 1'b0;
    endtask

    task automatic check_reg(cfg_addr_t addr, cfg_data_t expected, string name);
        cfg_addr = addr;
        #1;
        assert (cfg_rdata == expected) else begin
            reg_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, cfg_rdata, expected);
        end
    endtask

    // watchdog that ends a run which stops making progress
    initial begin
        for (int n = 0; n < 20000; n++) begin
            @(posedge clk);
        end
        $display("timeout, the test sequence did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        cfg_data_t saved_phase;
        cfg_data_t saved_freq;
        ext_rstb  = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        for (int i = 0; i < NTI; i++) din[i] = '0;
        repeat (5) @(posedge clk);
        #1 ext_rstb = 1'b1;

        for (int a = 0; a < 8; a++) begin
            check_reg(cfg_addr_t'(a), '0, "cfg_rdata_o after reset");
        end
        drive_on = 1'b1;

        // proportional only
        write_reg(ADDR_GAIN, 32'h3);
        wait_cycles(50);
        write_reg(ADDR_CTRL, 32'h4);
        wait_cycles(2);
        check_reg(ADDR_SNAP_FREQ, '0, "snap_freq");
        check_reg(ADDR_SNAP_PHASE, cfg_data_t'(m_snap_phase), "snap_phase");
        write_reg(ADDR_CTRL, 32'h0);

        // full second order loop with a detector offset
        write_reg(ADDR_PD_OFFSET, 32'hfffffff3);
        check_reg(ADDR_PD_OFFSET, 32'hfffffff3, "pd_offset");
        write_reg(ADDR_GAIN, 32'h13);
        check_reg(ADDR_GAIN, 32'h13, "gain");
        write_reg(ADDR_CTRL, 32'h1);
        wait_cycles(300);

        // override and release
        write_reg(ADDR_EXT_PI, 32'h5a);
        check_reg(ADDR_EXT_PI, 32'h5a, "ext_pi");
        write_reg(ADDR_CTRL, 32'h3);
        wait_cycles(40);
        write_reg(ADDR_CTRL, 32'h1);
        wait_cycles(40);

        // one capture per rising edge of the request bit
        write_reg(ADDR_CTRL, 32'h5);
        check_reg(ADDR_CTRL, 32'h5, "ctrl");
        wait_cycles(2);
        saved_phase = cfg_data_t'(m_snap_phase);
        saved_freq  = cfg_data_t'(signed'(m_snap_freq));
        check_reg(ADDR_SNAP_PHASE, saved_phase, "snap_phase");
        check_reg(ADDR_SNAP_FREQ, saved_freq, "snap_freq");
        wait_cycles(20);
        check_reg(ADDR_SNAP_PHASE, saved_phase, "snap_phase held");
        check_reg(ADDR_SNAP_FREQ, saved_freq, "snap_freq held");

        $display("errors: pi_ctl_o %0d, freq_lvl_cross_o %0d, readback %0d",
                 pi_errs, cross_errs, reg_errs);
        if (pi_errs + cross_errs + reg_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/cdr_pkg.sv
hw/mm_pd.sv
hw/cdr_loop_filter.sv
hw/cdr_cfg_regs.sv
hw/mm_cdr_top.sv
verif/mm_cdr_properties.sv
verif/tb_mm_cdr.sv

//--- Makefile
TOP := tb_mm_cdr

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
